// ==== divider_arbiter.sv ====
// Round-robin arbiter granting the shared divider and routing results back by tag

`include "tensor_div_defines.svh"

module divider_arbiter
  import tensor_div_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Channel side
  input  logic [`TD_NUM_CH-1:0] ch_req_valid,
  input  div_req_t              ch_req [`TD_NUM_CH],
  output logic [`TD_NUM_CH-1:0] ch_req_ready,
  output logic [`TD_NUM_CH-1:0] ch_rsp_valid,
  output div_rsp_t              ch_rsp,
  // Divider side
  output logic                  div_req_valid,
  output div_req_t              div_req,
  input  logic                  div_idle,
  input  logic                  div_rsp_valid,
  input  div_rsp_t              div_rsp
);

  localparam int N = `TD_NUM_CH;

  ch_tag_t        rr_ptr;
  ch_tag_t        gnt_idx;
  logic [N-1:0]   grant;

  ////////////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////////////

  // First requester at or after the pointer, only while the divider is idle
  always_comb begin
    int idx;
    grant   = '0;
    gnt_idx = '0;
    for (int off = 0; off < N; off++) begin
      idx = int'(rr_ptr) + off;
      if (idx >= N) begin
        idx = idx - N;
      end
      if ((grant == '0) && div_idle && ch_req_valid[idx]) begin
        grant[idx] = 1'b1;
        gnt_idx    = ch_tag_t'(idx);
      end
    end
  end

  assign ch_req_ready  = grant;
  assign div_req_valid = |grant;
  assign div_req       = ch_req[gnt_idx];

  // Pointer moves one past the winner
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rr_ptr <= '0;
    end else if (|grant) begin
      rr_ptr <= (int'(gnt_idx) == N - 1) ? '0 : ch_tag_t'(gnt_idx + 1'b1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response fan-out
  ////////////////////////////////////////////////////////////////////////////

  // Payload is broadcast, valid decoded from tag
  always_comb begin
    for (int c = 0; c < N; c++) begin
      ch_rsp_valid[c] = div_rsp_valid && (div_rsp.tag == ch_tag_t'(c));
    end
  end

  assign ch_rsp = div_rsp;

endmodule

// ==== seq_divider.sv ====
// Restoring radix-2 unsigned divider, one quotient bit per cycle, tag kept with the operation

`include "tensor_div_defines.svh"

module seq_divider
  import tensor_div_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     req_valid,
  input  div_req_t req,
  output logic     idle,
  output logic     rsp_valid,
  output div_rsp_t rsp
);

  localparam int W     = `TD_DATA_W;
  localparam int CNT_W = $clog2(W + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic             busy;
  logic [CNT_W-1:0] step_cnt;
  // Dividend bits shift out at the top, quotient bits shift in at the bottom
  logic [W-1:0]     quot_q;
  logic [W-1:0]     rem_q;
  logic [W-1:0]     divisor_q;
  ch_tag_t          tag_q;
  // Partial remainder with the next dividend bit appended
  logic [W:0]       trial;
  logic [W:0]       diff;
  logic             accept;

  assign accept = req_valid && !busy;
  assign idle   = !busy;

  assign trial = {rem_q, quot_q[W-1]};
  // Top bit set means the trial subtraction borrowed
  assign diff  = trial - {1'b0, divisor_q};

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  // Accept edge, then W step edges, then one edge to raise rsp_valid
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      if (accept) begin
        busy     <= 1'b1;
        step_cnt <= CNT_W'(W);
      end else if (busy) begin
        if (step_cnt != '0) begin
          step_cnt <= step_cnt - 1'b1;
        end else begin
          // All bits done
          busy      <= 1'b0;
          rsp_valid <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      quot_q    <= req.ops.a;
      rem_q     <= '0;
      divisor_q <= req.ops.b;
      tag_q     <= req.tag;
    end else if (busy && (step_cnt != '0)) begin
      if (!diff[W]) begin
        // Fits, keep the difference
        rem_q  <= diff[W-1:0];
        quot_q <= {quot_q[W-2:0], 1'b1};
      end else begin
        // Restore
        rem_q  <= trial[W-1:0];
        quot_q <= {quot_q[W-2:0], 1'b0};
      end
    end
  end

  // Zero divisor never borrows, so quotient ends all ones and remainder equals A
  assign rsp.quot = quot_q;
  assign rsp.rem  = rem_q;
  assign rsp.dbz  = (divisor_q == '0);
  assign rsp.tag  = tag_q;

endmodule

// ==== sources.f ====
+incdir+.
tensor_div_pkg.sv
seq_divider.sv
divider_arbiter.sv
tensor_div_channel.sv
tensor_div_top.sv
tb_tensor_div_top.sv

// ==== tb_tensor_div_top.sv ====
// Directed testbench for tensor_div_top with reference model, credit hosts and consumers

`include "tensor_div_defines.svh"

module tb_tensor_div_top
  import tensor_div_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N          = `TD_NUM_CH;
  localparam int MAX_ELEMS  = 64;
  // Consumer never has more credits outstanding than this
  localparam int OUT_WINDOW = 4;
  localparam int ALL        = -1;

  logic          CLK;
  logic          RST;
  logic [N-1:0]  start;
  tensor_shape_t shape [N];
  logic [N-1:0]  done;
  logic [N-1:0]  in_valid;
  operand_pair_t in_pair [N];
  logic [N-1:0]  in_credit;
  logic [N-1:0]  out_credit;
  logic [N-1:0]  out_valid;
  quot_elem_t    out_elem [N];

  // Per-channel tensor bookkeeping
  operand_pair_t ops_mem [N][MAX_ELEMS];
  tensor_shape_t shape_q [N];
  int            total [N];
  int            sent_cnt [N];
  int            recv_cnt [N];
  int            host_credit [N];
  // Credit count rebuilt from in_valid and in_credit as seen on the ports
  int            port_credit [N];
  int            credit_pulses [N];
  int            grant_cap [N];
  int            granted [N];
  int            outstanding [N];
  int            done_cnt [N];
  int            dbz_cnt [N];

  tensor_div_top u_dut (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .shape      (shape),
    .done       (done),
    .in_valid   (in_valid),
    .in_pair    (in_pair),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_elem   (out_elem)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Zero divisor gives all-ones quotient and A as remainder
  function automatic quot_elem_t model_elem(input operand_pair_t op, input logic last);
    quot_elem_t e;
    if (op.b == '0) begin
      e.quot = '1;
      e.rem  = op.a;
      e.dbz  = 1'b1;
    end else begin
      e.quot = op.a / op.b;
      e.rem  = op.a % op.b;
      e.dbz  = 1'b0;
    end
    e.last = last;
    return e;
  endfunction

  function automatic tensor_shape_t make_shape(input int i, input int j, input int k);
    tensor_shape_t s;
    s.i = `TD_DIM_W'(i);
    s.j = `TD_DIM_W'(j);
    s.k = `TD_DIM_W'(k);
    return s;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Hosts and consumers
  ////////////////////////////////////////////////////////////////////////////

  // Host sends only while it holds an input credit
  always @(posedge CLK) begin : host
    if (!RST) begin
      for (int c = 0; c < N; c++) begin
        // Pair taken by the DUT at this edge against credits returned
        port_credit[c] = port_credit[c] + int'(in_credit[c]) - int'(in_valid[c]);
        if (port_credit[c] < 0) begin
          abort_run($sformatf("Host %0d credit count went below zero", c));
        end
        if (in_credit[c]) begin
          host_credit[c]++;
          credit_pulses[c]++;
          if (host_credit[c] > `TD_IN_CREDITS) begin
            abort_run($sformatf("Channel %0d returned more input credits than it got", c));
          end
        end
        if ((host_credit[c] > 0) && (sent_cnt[c] < total[c])) begin
          in_valid[c] <= 1'b1;
          in_pair[c]  <= ops_mem[c][sent_cnt[c]];
          sent_cnt[c]++;
          host_credit[c]--;
        end else begin
          in_valid[c] <= 1'b0;
        end
      end
    end
  end

  // Consumer checks each element and grants credits with random gaps
  always @(posedge CLK) begin : consumer
    quot_elem_t exp_e;
    if (!RST) begin
      for (int c = 0; c < N; c++) begin
        check_eq($sformatf("ch%0d done", c), done[c],
                 out_valid[c] && (recv_cnt[c] == total[c] - 1));
        if (done[c]) begin
          done_cnt[c]++;
        end
        if (out_valid[c]) begin
          if (recv_cnt[c] >= total[c]) begin
            abort_run($sformatf("Channel %0d emitted an element past the end of its tensor", c));
          end
          exp_e = model_elem(ops_mem[c][recv_cnt[c]], recv_cnt[c] == total[c] - 1);
          check_eq($sformatf("ch%0d elem %0d quot", c, recv_cnt[c]), out_elem[c].quot, exp_e.quot);
          check_eq($sformatf("ch%0d elem %0d rem", c, recv_cnt[c]), out_elem[c].rem, exp_e.rem);
          check_eq($sformatf("ch%0d elem %0d dbz", c, recv_cnt[c]), out_elem[c].dbz, exp_e.dbz);
          check_eq($sformatf("ch%0d elem %0d last", c, recv_cnt[c]), out_elem[c].last, exp_e.last);
          if (out_elem[c].dbz) begin
            dbz_cnt[c]++;
          end
          recv_cnt[c]++;
          outstanding[c]--;
        end
        if ((granted[c] < grant_cap[c]) && (outstanding[c] < OUT_WINDOW) &&
            (($urandom % 4) != 0)) begin
          out_credit[c] <= 1'b1;
          granted[c]++;
          outstanding[c]++;
        end else begin
          out_credit[c] <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////////////////////////////////////////

  // Bookkeeping changes at the falling edge, away from the sampling edge
  task automatic prepare_tensor(input int c, input tensor_shape_t s, input int zero_at,
                                input int cap);
    int n;
    @(negedge CLK);
    n = int'(s.i) * int'(s.j) * int'(s.k);
    if (n > MAX_ELEMS) begin
      abort_run("Tensor shape is larger than the testbench buffers");
    end
    check_eq($sformatf("ch%0d host credits before start", c), host_credit[c], `TD_IN_CREDITS);
    for (int e = 0; e < n; e++) begin
      ops_mem[c][e].a = 16'($urandom);
      ops_mem[c][e].b = (e == zero_at) ? '0 : 16'(($urandom % 1000) + 1);
    end
    shape_q[c]       = s;
    sent_cnt[c]      = 0;
    recv_cnt[c]      = 0;
    credit_pulses[c] = 0;
    granted[c]       = 0;
    outstanding[c]   = 0;
    done_cnt[c]      = 0;
    dbz_cnt[c]       = 0;
    grant_cap[c]     = (cap == ALL) ? n : cap;
    total[c]         = n;
  endtask

  task automatic launch(input logic [N-1:0] mask);
    @(posedge CLK);
    for (int c = 0; c < N; c++) begin
      if (mask[c]) begin
        shape[c] <= shape_q[c];
      end
    end
    start <= mask;
    @(posedge CLK);
    start <= '0;
  endtask

  task automatic wait_done(input int c, input int limit);
    int cyc;
    cyc = 0;
    while ((done_cnt[c] == 0) && (cyc < limit)) begin
      @(negedge CLK);
      cyc++;
    end
    if (done_cnt[c] == 0) begin
      abort_run($sformatf("Timeout: channel %0d never signalled done", c));
    end
  endtask

  // Quiet period, then one done, every element, credits all home
  task automatic check_tensor_end(input int c);
    repeat (30) @(negedge CLK);
    check_eq($sformatf("ch%0d done pulses", c), done_cnt[c], 1);
    check_eq($sformatf("ch%0d elements", c), recv_cnt[c], total[c]);
    check_eq($sformatf("ch%0d host credits", c), host_credit[c], `TD_IN_CREDITS);
  endtask

  task automatic test_single_element();
    prepare_tensor(0, make_shape(1, 1, 1), ALL, ALL);
    launch(2'b01);
    wait_done(0, 300);
    check_tensor_end(0);
  endtask

  task automatic test_tensor_2x2x3();
    prepare_tensor(0, make_shape(2, 2, 3), ALL, ALL);
    launch(2'b01);
    wait_done(0, 2000);
    check_tensor_end(0);
  endtask

  task automatic test_divide_by_zero();
    prepare_tensor(1, make_shape(1, 2, 3), 4, ALL);
    launch(2'b10);
    wait_done(1, 2000);
    check_tensor_end(1);
    check_eq("ch1 flagged elements", dbz_cnt[1], 1);
  endtask

  // Shared divider has to serve both channels for both to finish
  task automatic test_both_channels();
    prepare_tensor(0, make_shape(2, 3, 2), ALL, ALL);
    prepare_tensor(1, make_shape(3, 1, 3), ALL, ALL);
    launch(2'b11);
    wait_done(0, 4000);
    wait_done(1, 4000);
    check_tensor_end(0);
    check_tensor_end(1);
  endtask

  task automatic test_back_pressure();
    prepare_tensor(0, make_shape(1, 2, 4), ALL, 2);
    launch(2'b01);
    // Long enough for several divisions if nothing held the channel back
    repeat (200) @(negedge CLK);
    check_eq("ch0 elements under back-pressure", recv_cnt[0], 2);
    check_eq("ch0 done under back-pressure", done_cnt[0], 0);
    check_eq("ch0 host credits under back-pressure", host_credit[0], 0);
    grant_cap[0] = total[0];
    wait_done(0, 2000);
    check_tensor_end(0);
  endtask

  task automatic test_input_credits();
    prepare_tensor(1, make_shape(3, 1, 3), ALL, ALL);
    launch(2'b10);
    wait_done(1, 3000);
    check_tensor_end(1);
    check_eq("ch1 in_credit pulses", credit_pulses[1], total[1]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(98));
    RST        = 1'b1;
    start      = '0;
    in_valid   = '0;
    out_credit = '0;
    for (int c = 0; c < N; c++) begin
      shape[c]       = '0;
      in_pair[c]     = '0;
      total[c]       = 0;
      sent_cnt[c]    = 0;
      recv_cnt[c]    = 0;
      grant_cap[c]   = 0;
      granted[c]     = 0;
      outstanding[c] = 0;
      done_cnt[c]    = 0;
      dbz_cnt[c]     = 0;
      host_credit[c] = `TD_IN_CREDITS;
      port_credit[c] = `TD_IN_CREDITS;
      credit_pulses[c] = 0;
    end
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    check_eq("out_valid after reset", out_valid, '0);
    check_eq("done after reset", done, '0);
    check_eq("in_credit after reset", in_credit, '0);

    test_single_element();
    test_tensor_2x2x3();
    test_divide_by_zero();
    test_both_channels();
    test_back_pressure();
    test_input_credits();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== tensor_div_channel.sv ====
// Per-channel I x J x K loop controller with operand buffer and credit handling

`include "tensor_div_defines.svh"

module tensor_div_channel
  import tensor_div_pkg::*;
#(
  parameter int CH_ID = 0
) (
  input  logic          CLK,
  input  logic          RST,
  // Tensor control
  input  logic          start,
  input  tensor_shape_t shape,
  output logic          done,
  // Host operands
  input  logic          in_valid,
  input  operand_pair_t in_pair,
  output logic          in_credit,
  // Consumer results
  input  logic          out_credit,
  output logic          out_valid,
  output quot_elem_t    out_elem,
  // Shared divider via arbiter
  output logic          req_valid,
  output div_req_t      req,
  input  logic          req_ready,
  input  logic          rsp_valid,
  input  div_rsp_t      rsp
);

  localparam int DEPTH = `TD_IN_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_EMIT
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  state_t                     state;
  tensor_shape_t              shape_q;
  logic [`TD_DIM_W-1:0]       idx_i;
  logic [`TD_DIM_W-1:0]       idx_j;
  logic [`TD_DIM_W-1:0]       idx_k;
  logic                       i_end;
  logic                       j_end;
  logic                       k_end;
  // Operand buffer
  operand_pair_t              op_buf [DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           buf_cnt;
  // Output credits from the consumer
  logic [`TD_OUT_CREDIT_W-1:0] out_cnt;
  quot_elem_t                 elem_q;
  logic                       issue_fire;
  logic                       emit_fire;

  assign i_end = (idx_i == shape_q.i - 1'b1);
  assign j_end = (idx_j == shape_q.j - 1'b1);
  assign k_end = (idx_k == shape_q.k - 1'b1);

  // Request straight from the buffer head, held stable until granted
  assign req_valid  = (state == ST_ISSUE) && (buf_cnt != '0);
  assign req.ops    = op_buf[rd_ptr];
  assign req.tag    = ch_tag_t'(CH_ID);
  assign issue_fire = req_valid && req_ready;
  assign emit_fire  = (state == ST_EMIT) && (out_cnt != '0);

  assign out_elem = elem_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand buffer and credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      op_buf[wr_ptr] <= in_pair;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      buf_cnt   <= '0;
      in_credit <= 1'b0;
      out_cnt   <= '0;
    end else begin
      // Host never sends without credit, so no overflow check
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      buf_cnt   <= buf_cnt + CNT_W'(in_valid) - CNT_W'(issue_fire);
      // One credit back per popped pair
      in_credit <= issue_fire;
      out_cnt   <= out_cnt + `TD_OUT_CREDIT_W'(out_credit)
                   - `TD_OUT_CREDIT_W'(emit_fire);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Loop FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      shape_q   <= '0;
      idx_i     <= '0;
      idx_j     <= '0;
      idx_k     <= '0;
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      done      <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Start only taken here
          if (start) begin
            shape_q <= shape;
            idx_i   <= '0;
            idx_j   <= '0;
            idx_k   <= '0;
            state   <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (issue_fire) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (rsp_valid) begin
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          // Finished element held here until the consumer has room
          if (emit_fire) begin
            out_valid <= 1'b1;
            done      <= elem_q.last;
            // k fastest, then j, then i
            if (!k_end) begin
              idx_k <= idx_k + 1'b1;
            end else begin
              idx_k <= '0;
              if (!j_end) begin
                idx_j <= idx_j + 1'b1;
              end else begin
                idx_j <= '0;
                idx_i <= idx_i + 1'b1;
              end
            end
            state <= elem_q.last ? ST_IDLE : ST_ISSUE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Result capture, last from the indices of this element
  always_ff @(posedge CLK) begin
    if ((state == ST_WAIT) && rsp_valid) begin
      elem_q.quot <= rsp.quot;
      elem_q.rem  <= rsp.rem;
      elem_q.dbz  <= rsp.dbz;
      elem_q.last <= i_end && j_end && k_end;
    end
  end

endmodule

// ==== tensor_div_defines.svh ====
// Width, channel count and credit depth macros for the tensor divider

`ifndef TENSOR_DIV_DEFINES_SVH
`define TENSOR_DIV_DEFINES_SVH

// Operand, quotient and remainder width
`define TD_DATA_W 16

// Width of one tensor dimension size (I, J or K)
`define TD_DIM_W 4

// Channels sharing the one divider
`define TD_NUM_CH 2

// Operand buffer depth per channel, also the host's starting credit count
`define TD_IN_CREDITS 2

// Output credit counter width in a channel
`define TD_OUT_CREDIT_W 3

`endif

// ==== tensor_div_pkg.sv ====
// Packed struct types shared by the channels, the arbiter, the divider and the top

`include "tensor_div_defines.svh"

package tensor_div_pkg;

  // Channel tag width, one tag value per channel
  localparam int TAG_W = $clog2(`TD_NUM_CH);

  typedef logic [TAG_W-1:0] ch_tag_t;

  // Loop bounds, zero sizes are not allowed
  typedef struct packed {
    logic [`TD_DIM_W-1:0] i;
    logic [`TD_DIM_W-1:0] j;
    logic [`TD_DIM_W-1:0] k;
  } tensor_shape_t;

  // Dividend and divisor
  typedef struct packed {
    logic [`TD_DATA_W-1:0] a;
    logic [`TD_DATA_W-1:0] b;
  } operand_pair_t;

  // Request to the shared divider
  typedef struct packed {
    operand_pair_t ops;
    ch_tag_t       tag;
  } div_req_t;

  // Divider result, tag picks the channel it goes back to
  typedef struct packed {
    logic [`TD_DATA_W-1:0] quot;
    logic [`TD_DATA_W-1:0] rem;
    logic                  dbz;
    ch_tag_t               tag;
  } div_rsp_t;

  // One element as emitted by a channel
  typedef struct packed {
    logic [`TD_DATA_W-1:0] quot;
    logic [`TD_DATA_W-1:0] rem;
    logic                  dbz;
    logic                  last;
  } quot_elem_t;

endpackage

// ==== tensor_div_top.sv ====
// Top level joining the tensor channels, the arbiter and the shared divider

`include "tensor_div_defines.svh"

module tensor_div_top
  import tensor_div_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic [`TD_NUM_CH-1:0] start,
  input  tensor_shape_t         shape [`TD_NUM_CH],
  output logic [`TD_NUM_CH-1:0] done,
  input  logic [`TD_NUM_CH-1:0] in_valid,
  input  operand_pair_t         in_pair [`TD_NUM_CH],
  output logic [`TD_NUM_CH-1:0] in_credit,
  input  logic [`TD_NUM_CH-1:0] out_credit,
  output logic [`TD_NUM_CH-1:0] out_valid,
  output quot_elem_t            out_elem [`TD_NUM_CH]
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic [`TD_NUM_CH-1:0] ch_req_valid;
  div_req_t              ch_req [`TD_NUM_CH];
  logic [`TD_NUM_CH-1:0] ch_req_ready;
  logic [`TD_NUM_CH-1:0] ch_rsp_valid;
  div_rsp_t              ch_rsp;
  logic                  div_req_valid;
  div_req_t              div_req;
  logic                  div_idle;
  logic                  div_rsp_valid;
  div_rsp_t              div_rsp;

  // One channel per tensor stream, tag equals index
  for (genvar c = 0; c < `TD_NUM_CH; c++) begin : g_ch
    tensor_div_channel #(
      .CH_ID(c)
    ) u_channel (
      .CLK        (CLK),
      .RST        (RST),
      .start      (start[c]),
      .shape      (shape[c]),
      .done       (done[c]),
      .in_valid   (in_valid[c]),
      .in_pair    (in_pair[c]),
      .in_credit  (in_credit[c]),
      .out_credit (out_credit[c]),
      .out_valid  (out_valid[c]),
      .out_elem   (out_elem[c]),
      .req_valid  (ch_req_valid[c]),
      .req        (ch_req[c]),
      .req_ready  (ch_req_ready[c]),
      .rsp_valid  (ch_rsp_valid[c]),
      .rsp        (ch_rsp)
    );
  end

  divider_arbiter u_arbiter (
    .CLK           (CLK),
    .RST           (RST),
    .ch_req_valid  (ch_req_valid),
    .ch_req        (ch_req),
    .ch_req_ready  (ch_req_ready),
    .ch_rsp_valid  (ch_rsp_valid),
    .ch_rsp        (ch_rsp),
    .div_req_valid (div_req_valid),
    .div_req       (div_req),
    .div_idle      (div_idle),
    .div_rsp_valid (div_rsp_valid),
    .div_rsp       (div_rsp)
  );

  // The single shared divider
  seq_divider u_divider (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (div_req_valid),
    .req       (div_req),
    .idle      (div_idle),
    .rsp_valid (div_rsp_valid),
    .rsp       (div_rsp)
  );

endmodule
